//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
TOP = step_adapt_tb
FILELIST = step_adapt.f
OBJ_DIR = obj_dir
LOG = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST)) step_settings.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/arith_if.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

interface arith_if;
	logic start;
	logic [`WORD_SIZE-1:0] a;
	logic [`WORD_SIZE-1:0] b;
	logic [`WORD_SIZE-1:0] result;
	logic overflow;
	logic done;

	modport master (output start, a, b, input result, overflow, done);

	modport slave (input start, a, b, output result, overflow, done);
endinterface

`default_nettype wire

//--- design/error_accumulator.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

module error_accumulator (
	input  logic clk,
	input  logic arst_n,
	input  logic clear,
	input  logic add,
	input  logic [`WORD_SIZE-1:0] x0,
	input  logic [`WORD_SIZE-1:0] x1,
	input  logic [`WORD_SIZE-1:0] tolerance,
	output logic [`WORD_SIZE-1:0] error,
	output logic within_tol
);
	logic [`WORD_SIZE-1:0] diff;
	logic [`WORD_SIZE:0] sum;

	// Absolute difference of the pair
	assign diff = (x0 >= x1) ? (x0 - x1) : (x1 - x0);

	// Extra bit catches the carry for saturation
	assign sum = {1'b0, error} + {1'b0, diff};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			error <= '0;
		end else if (clear) begin
			error <= '0;
		end else if (add) begin
			if (sum[`WORD_SIZE]) begin
				error <= '1;
			end else begin
				error <= sum[`WORD_SIZE-1:0];
			end
		end
	end

	assign within_tol = (error <= tolerance);

endmodule

`default_nettype wire

//--- design/seq_divider.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

module seq_divider (
	input logic clk,
	input logic arst_n,
	arith_if.slave op
);
	localparam int W = `WORD_SIZE;
	localparam int F = `FRAC_BITS;
	localparam int QW = W + F;
	localparam int CW = $clog2(QW);

	logic busy;
	logic done_r;
	logic [CW-1:0] count;
	logic [QW-1:0] dvd;
	logic [W-1:0] dsr;
	logic [W-1:0] rem;
	logic [QW-1:0] quo;
	logic [W:0] trial;
	logic fits;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			done_r <= 1'b0;
			count <= '0;
		end else begin
			done_r <= 1'b0;
			if (busy) begin
				count <= count + 1'b1;
				if (count == CW'(QW - 1)) begin
					busy <= 1'b0;
					done_r <= 1'b1;
				end
			end else if (op.start) begin
				busy <= 1'b1;
				count <= '0;
			end
		end
	end

	// Partial remainder with the next dividend bit brought down
	assign trial = {rem, dvd[QW-1]};
	assign fits = (trial >= {1'b0, dsr});

	always_ff @(posedge clk) begin
		if (busy) begin
			if (fits) begin
				rem <= W'(trial - {1'b0, dsr});
			end else begin
				rem <= trial[W-1:0];
			end
			quo <= {quo[QW-2:0], fits};
			dvd <= dvd << 1;
		end else if (op.start) begin
			dvd <= {op.a, {F{1'b0}}};
			dsr <= op.b;
			rem <= '0;
			quo <= '0;
		end
	end

	assign op.done = done_r;
	assign op.result = quo[W-1:0];
	assign op.overflow = (dsr == '0) || (|quo[QW-1:W]);

endmodule

`default_nettype wire

//--- design/seq_multiplier.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

module seq_multiplier (
	input logic clk,
	input logic arst_n,
	arith_if.slave op
);
	localparam int W = `WORD_SIZE;
	localparam int F = `FRAC_BITS;
	localparam int CW = $clog2(W);

	logic busy;
	logic done_r;
	logic [CW-1:0] count;
	logic [2*W-1:0] mcand;
	logic [W-1:0] mplier;
	logic [2*W-1:0] prod;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			done_r <= 1'b0;
			count <= '0;
		end else begin
			done_r <= 1'b0;
			if (busy) begin
				count <= count + 1'b1;
				if (count == CW'(W - 1)) begin
					busy <= 1'b0;
					done_r <= 1'b1;
				end
			end else if (op.start) begin
				busy <= 1'b1;
				count <= '0;
			end
		end
	end

	// Shift-add datapath, one multiplier bit per cycle
	always_ff @(posedge clk) begin
		if (busy) begin
			if (mplier[0]) begin
				prod <= prod + mcand;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end else if (op.start) begin
			mcand <= {{W{1'b0}}, op.a};
			mplier <= op.b;
			prod <= '0;
		end
	end

	assign op.done = done_r;
	assign op.result = prod[W+F-1:F];
	// Anything left above the rescaled word is lost
	assign op.overflow = |prod[2*W-1:W+F];

endmodule

`default_nettype wire

//--- design/solution_memory.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

module solution_memory (
	input  logic clk,
	input  logic arst_n,
	input  logic we,
	input  logic [`ADDRESS_WIDTH-1:0] waddr,
	input  logic [`WORD_SIZE-1:0] wdata,
	input  logic [`ADDRESS_WIDTH-1:0] raddr1,
	output logic [`WORD_SIZE-1:0] rdata1,
	input  logic [`ADDRESS_WIDTH-1:0] raddr2,
	output logic [`WORD_SIZE-1:0] rdata2
);
	localparam int DEPTH = 1 << `ADDRESS_WIDTH;

	logic [`WORD_SIZE-1:0] mem [0:DEPTH-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Asynchronous read ports
	assign rdata1 = mem[raddr1];
	assign rdata2 = mem[raddr2];

endmodule

`default_nettype wire

//--- design/step_adapt_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

module step_adapt_unit (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  logic [`ADDRESS_WIDTH-1:0] x0_base,
	input  logic [`ADDRESS_WIDTH-1:0] x1_base,
	input  logic wr_en,
	input  logic [`ADDRESS_WIDTH-1:0] wr_addr,
	input  logic [`WORD_SIZE-1:0] wr_data,
	output logic done,
	output logic proceed,
	output logic error_failure,
	output logic [`WORD_SIZE-1:0] step_out
);
	logic [`ADDRESS_WIDTH-1:0] rd_addr1;
	logic [`ADDRESS_WIDTH-1:0] rd_addr2;
	logic [`WORD_SIZE-1:0] rd_data1;
	logic [`WORD_SIZE-1:0] rd_data2;
	logic wb_en;
	logic [`ADDRESS_WIDTH-1:0] wb_addr;
	logic [`WORD_SIZE-1:0] wb_data;
	logic mem_we;
	logic [`ADDRESS_WIDTH-1:0] mem_waddr;
	logic [`WORD_SIZE-1:0] mem_wdata;
	logic acc_clear;
	logic acc_add;
	logic [`WORD_SIZE-1:0] tolerance;
	logic [`WORD_SIZE-1:0] error;
	logic within_tol;

	arith_if mul_bus ();
	arith_if div_bus ();

	// Step write-back wins over the external loader
	assign mem_we = wb_en | wr_en;
	assign mem_waddr = wb_en ? wb_addr : wr_addr;
	assign mem_wdata = wb_en ? wb_data : wr_data;

	solution_memory u_memory (
		.clk(clk),
		.arst_n(arst_n),
		.we(mem_we),
		.waddr(mem_waddr),
		.wdata(mem_wdata),
		.raddr1(rd_addr1),
		.rdata1(rd_data1),
		.raddr2(rd_addr2),
		.rdata2(rd_data2)
	);

	step_control u_control (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.x0_base(x0_base),
		.x1_base(x1_base),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.acc_clear(acc_clear),
		.acc_add(acc_add),
		.tolerance(tolerance),
		.error(error),
		.within_tol(within_tol),
		.mul(mul_bus.master),
		.div(div_bus.master),
		.done(done),
		.proceed(proceed),
		.error_failure(error_failure),
		.step_out(step_out)
	);

	error_accumulator u_accumulator (
		.clk(clk),
		.arst_n(arst_n),
		.clear(acc_clear),
		.add(acc_add),
		.x0(rd_data1),
		.x1(rd_data2),
		.tolerance(tolerance),
		.error(error),
		.within_tol(within_tol)
	);

	seq_multiplier u_multiplier (
		.clk(clk),
		.arst_n(arst_n),
		.op(mul_bus.slave)
	);

	seq_divider u_divider (
		.clk(clk),
		.arst_n(arst_n),
		.op(div_bus.slave)
	);

endmodule

`default_nettype wire

//--- design/step_control.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

module step_control
	import step_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  logic [`ADDRESS_WIDTH-1:0] x0_base,
	input  logic [`ADDRESS_WIDTH-1:0] x1_base,
	output logic [`ADDRESS_WIDTH-1:0] rd_addr1,
	output logic [`ADDRESS_WIDTH-1:0] rd_addr2,
	input  logic [`WORD_SIZE-1:0] rd_data1,
	input  logic [`WORD_SIZE-1:0] rd_data2,
	output logic wb_en,
	output logic [`ADDRESS_WIDTH-1:0] wb_addr,
	output logic [`WORD_SIZE-1:0] wb_data,
	output logic acc_clear,
	output logic acc_add,
	output logic [`WORD_SIZE-1:0] tolerance,
	input  logic [`WORD_SIZE-1:0] error,
	input  logic within_tol,
	arith_if.master mul,
	arith_if.master div,
	output logic done,
	output logic proceed,
	output logic error_failure,
	output logic [`WORD_SIZE-1:0] step_out
);
	ctrl_state_t state;
	mul_sel_t mul_sel;

	logic [`WORD_SIZE-1:0] step_r;
	logic [`WORD_SIZE-1:0] pair_cnt;
	logic [`ADDRESS_WIDTH-1:0] addr1_r;
	logic [`ADDRESS_WIDTH-1:0] addr2_r;
	logic [`WORD_SIZE-1:0] prod_r;
	logic [`WORD_SIZE-1:0] new_step_r;
	logic ovf_r;
	logic fail_r;
	logic mul_start_r;
	logic div_start_r;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			tolerance <= '0;
			step_r <= '0;
			pair_cnt <= '0;
			addr1_r <= '0;
			addr2_r <= '0;
			prod_r <= '0;
			new_step_r <= '0;
			ovf_r <= 1'b0;
			fail_r <= 1'b0;
			mul_start_r <= 1'b0;
			div_start_r <= 1'b0;
			done <= 1'b0;
			proceed <= 1'b0;
			error_failure <= 1'b0;
			step_out <= '0;
		end else begin
			mul_start_r <= 1'b0;
			div_start_r <= 1'b0;
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						state <= LOAD_PARAMS;
					end
				end
				LOAD_PARAMS: begin
					pair_cnt <= rd_data1;
					tolerance <= rd_data2;
					state <= LOAD_STEP;
				end
				LOAD_STEP: begin
					step_r <= rd_data1;
					addr1_r <= x0_base;
					addr2_r <= x1_base;
					ovf_r <= 1'b0;
					state <= ACCUM;
				end
				ACCUM: begin
					// One pair per cycle until the counter runs out
					if (pair_cnt != '0) begin
						pair_cnt <= pair_cnt - 1'b1;
						addr1_r <= addr1_r + 1'b1;
						addr2_r <= addr2_r + 1'b1;
					end else begin
						mul_start_r <= 1'b1;
						state <= MUL_TOL;
					end
				end
				MUL_TOL: begin
					if (mul.done) begin
						prod_r <= mul.result;
						ovf_r <= ovf_r | mul.overflow;
						mul_start_r <= 1'b1;
						state <= MUL_SAFETY;
					end
				end
				MUL_SAFETY: begin
					if (mul.done) begin
						prod_r <= mul.result;
						ovf_r <= ovf_r | mul.overflow;
						div_start_r <= 1'b1;
						state <= DIVIDE;
					end
				end
				DIVIDE: begin
					if (div.done) begin
						new_step_r <= div.result;
						fail_r <= ovf_r | div.overflow | (error == '0);
						state <= WRITE_BACK;
					end
				end
				WRITE_BACK: begin
					done <= 1'b1;
					proceed <= !fail_r && within_tol;
					error_failure <= fail_r;
					step_out <= fail_r ? step_r : new_step_r;
					state <= FINISH;
				end
				FINISH: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Fixed parameter addresses first, then the walking pair addresses
	always_comb begin
		rd_addr1 = addr1_r;
		rd_addr2 = addr2_r;
		if (state == LOAD_PARAMS) begin
			rd_addr1 = `N_ADDR;
			rd_addr2 = `TOL_ADDR;
		end else if (state == LOAD_STEP) begin
			rd_addr1 = `STEP_ADDR;
		end
	end

	assign acc_clear = (state == IDLE) && start;
	assign acc_add = (state == ACCUM) && (pair_cnt != '0);

	// Failed runs leave the stored step alone
	assign wb_en = (state == WRITE_BACK) && !fail_r;
	assign wb_addr = `STEP_ADDR;
	assign wb_data = new_step_r;

	assign mul_sel = (state == MUL_SAFETY) ? MUL_SEL_SAFETY : MUL_SEL_TOL;
	assign mul.start = mul_start_r;
	assign mul.a = (mul_sel == MUL_SEL_SAFETY) ? prod_r : step_r;
	assign mul.b = (mul_sel == MUL_SEL_SAFETY) ? `STEP_SAFETY : tolerance;

	// q << FRAC_BITS / error happens inside the divider
	assign div.start = div_start_r;
	assign div.a = prod_r;
	assign div.b = error;

endmodule

`default_nettype wire

//--- design/step_pkg.sv
`default_nettype none

package step_pkg;

	typedef enum logic [3:0] {
		IDLE,
		LOAD_PARAMS,
		LOAD_STEP,
		ACCUM,
		MUL_TOL,
		MUL_SAFETY,
		DIVIDE,
		WRITE_BACK,
		FINISH
	} ctrl_state_t;

	// Second multiplier operand
	typedef enum logic {
		MUL_SEL_TOL,
		MUL_SEL_SAFETY
	} mul_sel_t;

endpackage

`default_nettype wire

//--- step_adapt.f
+incdir+.
design/step_pkg.sv
design/arith_if.sv
design/solution_memory.sv
design/error_accumulator.sv
design/seq_multiplier.sv
design/seq_divider.sv
design/step_control.sv
design/step_adapt_unit.sv
test/step_adapt_checker.sv
test/step_adapt_tb.sv

//--- step_settings.svh
`ifndef STEP_SETTINGS_SVH
`define STEP_SETTINGS_SVH

// Datapath word and memory geometry
`define WORD_SIZE 16
`define ADDRESS_WIDTH 4

// Q9.7 unsigned fixed point
`define FRAC_BITS 7

// 0.9 in fixed point
`define STEP_SAFETY 16'd115

// Fixed parameter locations in solution memory
`define N_ADDR 4'd0
`define TOL_ADDR 4'd1
`define STEP_ADDR 4'd2

`endif

//--- test/step_adapt_checker.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

module step_adapt_checker #(
	parameter int MAX_PAIRS = 6
) (
	input logic clk,
	input logic done,
	input logic proceed,
	input logic error_failure,
	input logic [`WORD_SIZE-1:0] step_out
);
	localparam int W = `WORD_SIZE;
	localparam longint WORD_MAX = (longint'(1) << W) - 1;

	int pass_count = 0;
	int fail_count = 0;
	string name_q[$];
	// Each entry packs {proceed, error_failure, step_out}
	logic [W+1:0] expected_q[$];

	function automatic logic [W+1:0] predict_step(
		input int n,
		input logic [W-1:0] tol,
		input logic [W-1:0] step,
		input logic [MAX_PAIRS-1:0][W-1:0] x0v,
		input logic [MAX_PAIRS-1:0][W-1:0] x1v
	);
		longint err;
		longint p;
		longint q;
		longint s;
		logic fail;
		logic ok;
		int i;
		err = 0;
		s = 0;
		fail = 1'b0;
		for (i = 0; i < n && i < MAX_PAIRS; i++) begin
			if (x0v[i] > x1v[i]) begin
				err = err + longint'(x0v[i] - x1v[i]);
			end else begin
				err = err + longint'(x1v[i] - x0v[i]);
			end
			if (err > WORD_MAX) begin
				err = WORD_MAX;
			end
		end
		// Three truncating stages, each limited to one word
		p = (longint'(step) * longint'(tol)) >> `FRAC_BITS;
		if (p > WORD_MAX) begin
			fail = 1'b1;
		end
		q = ((p & WORD_MAX) * longint'(`STEP_SAFETY)) >> `FRAC_BITS;
		if (err == 0) begin
			fail = 1'b1;
		end else begin
			s = ((q & WORD_MAX) << `FRAC_BITS) / err;
			if (s > WORD_MAX) begin
				fail = 1'b1;
			end
		end
		ok = !fail && (err <= longint'(tol));
		return {ok, fail, fail ? step : s[W-1:0]};
	endfunction

	task automatic expect_run(
		input string name,
		input int n,
		input logic [W-1:0] tol,
		input logic [W-1:0] step,
		input logic [MAX_PAIRS-1:0][W-1:0] x0v,
		input logic [MAX_PAIRS-1:0][W-1:0] x1v,
		output logic [W-1:0] stored_step
	);
		logic [W+1:0] expected;
		expected = predict_step(n, tol, step, x0v, x1v);
		name_q.push_back(name);
		expected_q.push_back(expected);
		// On failure the old step stays, which is also what step_out shows
		stored_step = expected[W-1:0];
	endtask

	task automatic missing_done(input int cycles);
		string name;
		logic [W+1:0] expected;
		name = name_q.pop_front();
		expected = expected_q.pop_front();
		fail_count++;
		$display("%s: no done strobe within %0d cycles of start (expected step %h)",
			name, cycles, expected[W-1:0]);
	endtask

	function automatic int pending_count();
		return expected_q.size();
	endfunction

	task automatic compare_outputs();
		string name;
		logic [W+1:0] expected;
		if (expected_q.size() == 0) begin
			fail_count++;
			$display("done strobe at %0t with no run pending", $time);
		end else begin
			name = name_q.pop_front();
			expected = expected_q.pop_front();
			if (proceed !== expected[W+1]) begin
				fail_count++;
				$display("FAILED %0t %s proceed expected %0b got %0b",
					$time, name, expected[W+1], proceed);
			end else if (error_failure !== expected[W]) begin
				fail_count++;
				$display("FAILED %0t %s error_failure expected %0b got %0b",
					$time, name, expected[W], error_failure);
			end else if (step_out !== expected[W-1:0]) begin
				fail_count++;
				$display("FAILED %0t %s step_out expected %h got %h",
					$time, name, expected[W-1:0], step_out);
			end else begin
				pass_count++;
				$display("ok %s step %h proceed %0b", name, step_out, proceed);
			end
		end
	endtask

	// Outputs settle after the rising edge
	always @(negedge clk) begin
		if (done) begin
			compare_outputs();
		end
	end

endmodule

`default_nettype wire

//--- test/step_adapt_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "step_settings.svh"

module step_adapt_tb;
	localparam int W = `WORD_SIZE;
	localparam int AW = `ADDRESS_WIDTH;
	localparam int DEPTH = 1 << AW;
	localparam int MAX_PAIRS = 6;
	localparam int CLK_PERIOD = 10;
	localparam int RANDOM_RUNS = 40;
	localparam int NUM_RUNS = 8 + RANDOM_RUNS;
	localparam int LOAD_CYCLES = DEPTH + 4;
	// Params, pairs, two multiplies, the divide and write-back
	localparam int RUN_CYCLES = 3 + MAX_PAIRS + 1 + 2 * (W + 2) + (W + `FRAC_BITS + 2) + 3;
	localparam int WATCHDOG_CYCLES = 5 + NUM_RUNS * (RUN_CYCLES + LOAD_CYCLES) + 200;

	logic clk;
	logic arst_n;
	logic start;
	logic [AW-1:0] x0_base;
	logic [AW-1:0] x1_base;
	logic wr_en;
	logic [AW-1:0] wr_addr;
	logic [W-1:0] wr_data;
	logic done;
	logic proceed;
	logic error_failure;
	logic [W-1:0] step_out;

	logic [W-1:0] shadow [0:DEPTH-1];

	step_adapt_unit UUT (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.x0_base(x0_base),
		.x1_base(x1_base),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.done(done),
		.proceed(proceed),
		.error_failure(error_failure),
		.step_out(step_out)
	);

	step_adapt_checker #(.MAX_PAIRS(MAX_PAIRS)) u_checker (
		.clk(clk),
		.done(done),
		.proceed(proceed),
		.error_failure(error_failure),
		.step_out(step_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic write_word(input logic [AW-1:0] addr, input logic [W-1:0] data);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge clk);
		wr_en = 1'b0;
		shadow[addr] = data;
	endtask

	task automatic load_params(input logic [W-1:0] n, input logic [W-1:0] tol,
		input logic [W-1:0] step);
		write_word(`N_ADDR, n);
		write_word(`TOL_ADDR, tol);
		write_word(`STEP_ADDR, step);
	endtask

	task automatic run_step(input string name, input logic [AW-1:0] b0,
		input logic [AW-1:0] b1);
		logic [MAX_PAIRS-1:0][W-1:0] x0v;
		logic [MAX_PAIRS-1:0][W-1:0] x1v;
		logic [W-1:0] next_step;
		logic [AW-1:0] a0;
		logic [AW-1:0] a1;
		int i;
		int cycles;
		// Pair addresses wrap around the memory
		for (i = 0; i < MAX_PAIRS; i++) begin
			a0 = b0 + AW'(i);
			a1 = b1 + AW'(i);
			x0v[i] = shadow[a0];
			x1v[i] = shadow[a1];
		end
		u_checker.expect_run(name, int'(shadow[`N_ADDR]), shadow[`TOL_ADDR],
			shadow[`STEP_ADDR], x0v, x1v, next_step);
		x0_base = b0;
		x1_base = b1;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 0;
		while (!done && cycles < 2 * RUN_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (done) begin
			shadow[`STEP_ADDR] = next_step;
		end else begin
			u_checker.missing_done(cycles);
		end
		@(negedge clk);
	endtask

	task automatic random_run(input int idx);
		int a;
		logic [W-1:0] n;
		logic [W-1:0] tol;
		logic [W-1:0] step;
		logic [AW-1:0] b0;
		logic [AW-1:0] b1;
		for (a = 3; a < DEPTH; a++) begin
			write_word(AW'(a), W'($urandom_range(0, 'h400)));
		end
		n = W'($urandom_range(1, MAX_PAIRS));
		tol = W'($urandom_range(1, 'h800));
		step = W'($urandom_range(1, 'h1000));
		b0 = AW'($urandom_range(0, DEPTH - 1));
		b1 = AW'($urandom_range(0, DEPTH - 1));
		load_params(n, tol, step);
		run_step($sformatf("random %0d", idx), b0, b1);
	endtask

	initial begin
		int i;
		void'($urandom(32'hd2ea0147));
		arst_n = 1'b0;
		start = 1'b0;
		x0_base = '0;
		x1_base = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		for (i = 0; i < DEPTH; i++) begin
			shadow[i] = '0;
		end
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);

		// Error 80 against tolerance 2.0
		load_params(2, 16'h0100, 16'h0080);
		write_word(4, 16'd300);
		write_word(5, 16'd100);
		write_word(10, 16'd250);
		write_word(11, 16'd130);
		run_step("accept", 4, 10);

		load_params(2, 16'h0100, 16'h0080);
		write_word(4, 16'd500);
		write_word(10, 16'd300);
		write_word(11, 16'd250);
		run_step("reject", 4, 10);

		load_params(3, 16'h0100, 16'h0080);
		for (i = 0; i < 3; i++) begin
			write_word(AW'(4 + i), W'(7 + i));
			write_word(AW'(10 + i), W'(7 + i));
		end
		run_step("zero error", 4, 10);

		load_params(0, 16'h0100, 16'h0080);
		run_step("n zero", 4, 10);

		load_params(1, 16'h4000, 16'hf000);
		write_word(4, 16'd1);
		write_word(10, 16'd0);
		run_step("multiply overflow", 4, 10);

		load_params(1, 16'h0100, 16'h2000);
		run_step("divide overflow", 4, 10);

		// Full-scale difference plus one more pins the error at the top
		load_params(2, 16'h0100, 16'h2000);
		write_word(4, 16'hffff);
		write_word(5, 16'h0001);
		write_word(10, 16'h0000);
		write_word(11, 16'h0000);
		run_step("saturate", 4, 10);

		write_word(4, 16'd10);
		write_word(5, 16'd11);
		write_word(10, 16'd11);
		write_word(11, 16'd10);
		run_step("write back", 4, 10);

		for (i = 0; i < RANDOM_RUNS; i++) begin
			random_run(i);
		end

		repeat (2) @(negedge clk);
		$display("tests passed %0d failed %0d", u_checker.pass_count,
			u_checker.fail_count + u_checker.pending_count());
		if (u_checker.fail_count == 0 && u_checker.pending_count() == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, test sequence did not finish",
			WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
